/* classSelector.sv */
`timescale 1ns/1ps

module classSelector import nnPkg::*;
(
	input  logic         clk,
	input  logic         reset,
	input  scoreVector_t scores,
	output classResult_t result
);

	logic [ClassWidth-1:0] bestIdx;
	activation_t           bestScore;

	// ~~~~~~~~~~~~~~~~~~~~
	// Argmax, first maximum kept
	// ~~~~~~~~~~~~~~~~~~~~

	always_comb
	begin
		bestIdx   = '0;
		bestScore = scores.score[0];
		for (int c = 1; c < NumClasses; c++)
		begin
			if (scores.score[c] > bestScore)        // Strict, so ties keep lower index
			begin
				bestIdx   = ClassWidth'(c);
				bestScore = scores.score[c];
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			result <= '0;
		end
		else
		begin
			result.classIdx <= bestIdx;
			result.score    <= bestScore;
		end
	end

endmodule

/* neuralClassifier.sv */
`timescale 1ns/1ps

module neuralClassifier import nnPkg::*;
#(
	// Node-major: weight i of node n sits at n * NumPixels + i
	parameter weight_t [0:NumPixels*NumHidden-1] HiddenWeights = '{
		4, -2, 7, 1, -5, 3, 6, -1, 2, 0, -3, 5, 1, -4, 2,       // Node 0
		-3, 6, 0, 2, 5, -1, -4, 7, 3, -2, 1, 0, 6, -5, 1,       // Node 1
		2, 1, -6, 4, 3, 5, -2, 0, -4, 6, 2, -1, 3, 1, -3,       // Node 2
		5, -4, 2, -3, 0, 4, 1, 3, -2, 2, 6, -3, 0, 4, -1        // Node 3
	},
	parameter weight_t [0:NumHidden-1] HiddenBiases = '{96, -40, 150, 32},
	parameter weight_t [0:NumHidden*NumClasses-1] OutputWeights = '{
		9, -3, 4, 2,                                            // Class 0
		-2, 8, 3, -1,                                           // Class 1
		3, 1, -4, 7                                             // Class 2
	},
	parameter weight_t [0:NumClasses-1] OutputBiases = '{200, 120, 64}
)
(
	input  logic         clk,
	input  logic         reset,
	input  pixelWord_t   pixelWord,
	output classResult_t result
);

	pixelVector_t  pixels;          // Decode stage, 1 edge
	hiddenVector_t hidden;          // Hidden layer, 3 edges
	scoreVector_t  scores;          // Output layer, 3 edges

	// ~~~~~~~~~~~~~~~~~~~~
	// Decode
	// ~~~~~~~~~~~~~~~~~~~~

	pixelDecoder decoder
	(
		.clk       (clk),
		.reset     (reset),
		.pixelWord (pixelWord),
		.pixels    (pixels)
	);

	// ~~~~~~~~~~~~~~~~~~~~
	// Execute
	// ~~~~~~~~~~~~~~~~~~~~

	neuralLayer
	#(
		.NumInputs (NumPixels),
		.NumNodes  (NumHidden),
		.Weights   (HiddenWeights),
		.Biases    (HiddenBiases)
	)
	hiddenLayer
	(
		.clk     (clk),
		.reset   (reset),
		.inputs  (pixels.act),
		.outputs (hidden.act)
	);

	neuralLayer
	#(
		.NumInputs (NumHidden),
		.NumNodes  (NumClasses),
		.Weights   (OutputWeights),
		.Biases    (OutputBiases)
	)
	outputLayer
	(
		.clk     (clk),
		.reset   (reset),
		.inputs  (hidden.act),
		.outputs (scores.score)
	);

	// ~~~~~~~~~~~~~~~~~~~~
	// Result
	// ~~~~~~~~~~~~~~~~~~~~

	classSelector selector
	(
		.clk    (clk),
		.reset  (reset),
		.scores (scores),
		.result (result)          // 8 edges after pixelWord
	);

endmodule

/* neuralClassifier_assertions.sv */
`timescale 1ns/1ps

module neuralClassifierAssertions import nnPkg::*;
(
	input logic         clk,
	input logic         reset,
	input classResult_t result
);

	// Only classes 0 to NumClasses-1 exist
	property classInRange;
		@(posedge clk) disable iff (reset) result.classIdx < NumClasses;
	endproperty

	property zeroAfterReset;
		@(posedge clk) reset |=> (result == '0);
	endproperty

	property noUnknown;
		@(posedge clk) disable iff (reset) !$isunknown(result);
	endproperty

	assert property (classInRange)
		else $error("class index out of range");
	assert property (zeroAfterReset)
		else $error("result not cleared by reset");
	assert property (noUnknown)
		else $error("result has unknown bits");

endmodule

bind neuralClassifier neuralClassifierAssertions resultChecks
(
	.clk    (clk),
	.reset  (reset),
	.result (result)
);

/* neuralLayer.sv */
`timescale 1ns/1ps

module neuralLayer import nnPkg::*;
#(
	parameter int                               NumInputs = NumPixels,
	parameter int                               NumNodes  = NumHidden,
	parameter weight_t [0:NumInputs*NumNodes-1] Weights   = '0,
	parameter weight_t [0:NumNodes-1]           Biases    = '0
)
(
	input  logic                        clk,
	input  logic                        reset,
	input  activation_t [NumInputs-1:0] inputs,
	output activation_t [NumNodes-1:0]  outputs
);

	// Row n of Weights holds the NumInputs weights of node n
	for (genvar n = 0; n < NumNodes; n++)
	begin : gNode
		neuronNode
		#(
			.NumInputs (NumInputs),
			.Weights   (Weights[n*NumInputs +: NumInputs]),
			.Bias      (Biases[n])
		)
		node
		(
			.clk        (clk),
			.reset      (reset),
			.inputs     (inputs),
			.activation (outputs[n])
		);
	end

endmodule

/* neuronNode.sv */
`timescale 1ns/1ps

module neuronNode import nnPkg::*;
#(
	parameter int                      NumInputs = NumPixels,
	parameter weight_t [0:NumInputs-1] Weights   = '0,
	parameter weight_t                 Bias      = '0
)
(
	input  logic                        clk,
	input  logic                        reset,
	input  activation_t [NumInputs-1:0] inputs,
	output activation_t                 activation
);

	localparam int FracBits = 5;                // Output taken from sum[12:5]

	activation_t [NumInputs-1:0] inputsReg;
	weight_t                     product [NumInputs];
	weight_t                     sumNext;
	weight_t                     sumReg;
	activation_t                 clampNext;

	// ~~~~~~~~~~~~~~~~~~~~
	// Stage 1: input register
	// ~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			inputsReg <= '0;
		end
		else
		begin
			inputsReg <= inputs;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~
	// Stage 2: weighted sum
	// ~~~~~~~~~~~~~~~~~~~~

	always_comb
	begin
		for (int i = 0; i < NumInputs; i++)
		begin
			// Activation is unsigned, so extend with zeros before the signed multiply
			product[i] = $signed({{(SumWidth-ActWidth){1'b0}}, inputsReg[i]}) * Weights[i];
		end
	end

	always_comb
	begin
		sumNext = Bias;
		for (int i = 0; i < NumInputs; i++)
		begin
			sumNext = sumNext + product[i];         // Wraps at 24 bits
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			sumReg <= '0;
		end
		else
		begin
			sumReg <= sumNext;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~
	// Stage 3: clamped ReLU
	// ~~~~~~~~~~~~~~~~~~~~

	always_comb
	begin
		if (sumReg[SumWidth-1])
			clampNext = '0;                         // Negative sum
		else if (sumReg >= SatLimit)
			clampNext = '1;                         // Saturate, 8192 included
		else
			clampNext = sumReg[FracBits +: ActWidth];
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			activation <= '0;
		end
		else
		begin
			activation <= clampNext;
		end
	end

endmodule

/* nnPkg.sv */
package nnPkg;

	// ~~~~~~~~~~~~~~~~~~~~
	// Widths and counts
	// ~~~~~~~~~~~~~~~~~~~~

	localparam int ActWidth   = 8;          // Activation and score
	localparam int SumWidth   = 24;         // Accumulator, weight and bias
	localparam int PixelWidth = 4;
	localparam int NumPixels  = 15;
	localparam int NumHidden  = 4;
	localparam int NumClasses = 3;
	localparam int SatLimit   = 8192;       // Inclusive clamp point
	localparam int ClassWidth = 2;

	typedef logic [ActWidth-1:0] activation_t;
	typedef logic signed [SumWidth-1:0] weight_t;

	// ~~~~~~~~~~~~~~~~~~~~
	// Frame and layer vectors
	// ~~~~~~~~~~~~~~~~~~~~

	typedef struct packed {
		logic [NumPixels-1:0][PixelWidth-1:0] pix;     // Pixel 0 in low nibble
	} pixelWord_t;

	typedef struct packed {
		activation_t [NumPixels-1:0] act;
	} pixelVector_t;

	typedef struct packed {
		activation_t [NumHidden-1:0] act;
	} hiddenVector_t;

	typedef struct packed {
		activation_t [NumClasses-1:0] score;
	} scoreVector_t;

	// Winning class with its score
	typedef struct packed {
		logic [ClassWidth-1:0] classIdx;
		activation_t           score;
	} classResult_t;

endpackage

/* pixelDecoder.sv */
`timescale 1ns/1ps

module pixelDecoder import nnPkg::*;
(
	input  logic         clk,
	input  logic         reset,
	input  pixelWord_t   pixelWord,
	output pixelVector_t pixels
);

	pixelVector_t expanded;

	// Replicating the nibble gives 17 * p, so 15 maps to 255
	always_comb
	begin
		for (int i = 0; i < NumPixels; i++)
		begin
			expanded.act[i] = {pixelWord.pix[i], pixelWord.pix[i]};
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			pixels <= '0;
		end
		else
		begin
			pixels <= expanded;            // One edge of latency
		end
	end

endmodule

/* runSim.sh */
#!/bin/sh
# Build and run with Verilator, then judge the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f sim.f --top-module tbNeuralClassifier \
	> build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }
./obj_dir/VtbNeuralClassifier > sim.log 2>&1
grep -q "Errors found" sim.log && { echo "FAIL"; exit 1; }
grep -q "No errors" sim.log && { echo "PASS"; exit 0; } || { echo "FAIL"; exit 1; }

/* sim.f */
nnPkg.sv
pixelDecoder.sv
neuronNode.sv
neuralLayer.sv
classSelector.sv
neuralClassifier.sv
neuralClassifier_assertions.sv
tbNeuralClassifier.sv

/* tbNeuralClassifier.sv */
`timescale 1ns/1ps

module tbNeuralClassifier import nnPkg::*;
();

	localparam int Depth      = 8;        // Edges from pixelWord to result
	localparam int StreamLen  = 64;
	localparam int LimitCycles = 16 + 2 * Depth + 8 * (Depth + 1) + StreamLen + Depth
		+ 40 + 200;

	// Node 1 goes negative, node 2 stays mid range, node 3 reaches 8192 on an all-15 frame
	localparam weight_t [0:NumPixels*NumHidden-1] TbHiddenWeights = '{
		4, -2, 3, 1, -1, 2, 3, -1, 2, 0, -2, 3, 1, -1, 2,
		-3, -3, -3, -3, -3, -3, -3, -3, -3, -3, -3, -3, -3, -3, -3,
		1, 1, 1, 1, 1, 1, 1, 1, 1, 1, 1, 1, 1, 1, 1,
		2, 2, 2, 2, 2, 2, 2, 2, 2, 2, 2, 2, 2, 2, 2
	};
	localparam weight_t [0:NumHidden-1] TbHiddenBiases = '{64, 100, 0, 542};
	localparam weight_t [0:NumHidden*NumClasses-1] TbOutputWeights = '{
		8, 0, 4, 1,
		0, 1, 21, 24,
		-4, 0, 0, 16
	};
	localparam weight_t [0:NumClasses-1] TbOutputBiases = '{-64, -400, -300};

	logic         clk;
	logic         reset;
	pixelWord_t   pixelWord;
	classResult_t result;

	int           errors = 0;
	int           checks = 0;
	logic [15:0]  lfsr = 16'd12850;
	classResult_t expQ[$];

	neuralClassifier
	#(
		.HiddenWeights (TbHiddenWeights),
		.HiddenBiases  (TbHiddenBiases),
		.OutputWeights (TbOutputWeights),
		.OutputBiases  (TbOutputBiases)
	)
	UUT
	(
		.clk       (clk),
		.reset     (reset),
		.pixelWord (pixelWord),
		.result    (result)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// ~~~~~~~~~~~~~~~~~~~~
	// Reference model
	// ~~~~~~~~~~~~~~~~~~~~

	function automatic activation_t clampRelu(weight_t s);
		if (s < 0)
			return '0;
		if (s >= SatLimit)
			return 8'd255;
		return activation_t'(s / 32);     // Bits 12 to 5
	endfunction

	function automatic classResult_t modelResult(pixelWord_t w);
		activation_t  px  [NumPixels];
		activation_t  hid [NumHidden];
		activation_t  sc  [NumClasses];
		weight_t      acc;
		classResult_t r;
		for (int i = 0; i < NumPixels; i++)
			px[i] = activation_t'(17 * w.pix[i]);
		for (int n = 0; n < NumHidden; n++)
		begin
			acc = TbHiddenBiases[n];
			for (int i = 0; i < NumPixels; i++)
				acc = acc + $signed({16'b0, px[i]}) * TbHiddenWeights[n*NumPixels+i];
			hid[n] = clampRelu(acc);
		end
		for (int c = 0; c < NumClasses; c++)
		begin
			acc = TbOutputBiases[c];
			for (int n = 0; n < NumHidden; n++)
				acc = acc + $signed({16'b0, hid[n]}) * TbOutputWeights[c*NumHidden+n];
			sc[c] = clampRelu(acc);
		end
		r.classIdx = '0;
		r.score    = sc[0];
		for (int c = 1; c < NumClasses; c++)
		begin
			if (sc[c] > r.score)
			begin
				r.classIdx = ClassWidth'(c);
				r.score    = sc[c];
			end
		end
		return r;
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~
	// Stimulus helpers
	// ~~~~~~~~~~~~~~~~~~~~

	function automatic logic lfsrBit();
		logic b;
		b = lfsr[0];
		lfsr = lfsr >> 1;
		if (b)
			lfsr = lfsr ^ 16'hB400;
		return b;
	endfunction

	function automatic pixelWord_t randomFrame();
		pixelWord_t w;
		for (int i = 0; i < NumPixels * PixelWidth; i++)
			w[i] = lfsrBit();
		return w;
	endfunction

	function automatic pixelWord_t flatFrame(logic [3:0] p);
		pixelWord_t w;
		for (int i = 0; i < NumPixels; i++)
			w.pix[i] = p;
		return w;
	endfunction

	task automatic checkResult(string name, classResult_t expected);
		checks++;
		if (result !== expected)
		begin
			errors++;
			$display("mismatch %s: expected class %0d score %0d, actual class %0d score %0d",
				name, expected.classIdx, expected.score, result.classIdx, result.score);
		end
	endtask

	task automatic runFrame(string name, pixelWord_t w);
		@(posedge clk);
		pixelWord <= w;
		repeat (Depth) @(posedge clk);
		@(negedge clk);
		checkResult(name, modelResult(w));
	endtask

	// ~~~~~~~~~~~~~~~~~~~~
	// Tests
	// ~~~~~~~~~~~~~~~~~~~~

	task automatic testAfterReset();
		for (int k = 0; k < 8; k++)
		begin
			@(negedge clk);
			checkResult("afterReset", '0);
		end
		@(posedge clk);
		pixelWord <= flatFrame(4'hF);
		for (int k = 0; k < Depth; k++)
		begin
			@(negedge clk);
			checkResult("afterReset", '0);
			@(posedge clk);
		end
	endtask

	task automatic testSingleFrame();
		runFrame("singleZero", flatFrame(4'h0));
		runFrame("singleFull", flatFrame(4'hF));
	endtask

	task automatic testClamps();
		pixelWord_t alt;
		for (int i = 0; i < NumPixels; i++)
			alt.pix[i] = i[0] ? 4'hF : 4'h0;
		runFrame("clampFull", flatFrame(4'hF));       // Hidden node 3 at exactly 8192
		runFrame("clampNegative", flatFrame(4'h0));
		runFrame("clampMid", flatFrame(4'h8));
		runFrame("clampAlternate", alt);
		runFrame("clampLow", flatFrame(4'h2));
	endtask

	task automatic testStreaming();
		pixelWord_t w;
		classResult_t exp;
		expQ.delete();
		for (int k = 0; k < StreamLen + Depth; k++)
		begin
			@(posedge clk);
			w = (k < StreamLen) ? randomFrame() : flatFrame(4'h0);
			pixelWord <= w;
			expQ.push_back(modelResult(w));
			@(negedge clk);
			if (expQ.size() > Depth)
			begin
				exp = expQ.pop_front();
				checkResult("streaming", exp);
			end
		end
	endtask

	task automatic testTies();
		runFrame("tieZeroScores", flatFrame(4'h0));  // All three scores are 0
	endtask

	task automatic testResetMidStream();
		for (int k = 0; k < 20; k++)
		begin
			@(posedge clk);
			pixelWord <= randomFrame();
		end
		@(posedge clk);
		reset <= 1'b1;
		pixelWord <= flatFrame(4'h0);
		repeat (4)
		begin
			@(posedge clk);
			@(negedge clk);
			checkResult("resetHeld", '0);
		end
		@(posedge clk);
		reset <= 1'b0;
		for (int k = 0; k < Depth + 2; k++)
		begin
			@(negedge clk);
			checkResult("resetRelease", modelResult(flatFrame(4'h0)));
			@(posedge clk);
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~
	// Main sequence and watchdog
	// ~~~~~~~~~~~~~~~~~~~~

	initial
	begin
		reset     = 1'b1;
		pixelWord = '0;
		repeat (16) @(posedge clk);
		reset <= 1'b0;
		testAfterReset();
		testSingleFrame();
		testClamps();
		testStreaming();
		testTies();
		testResetMidStream();
		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

	initial
	begin
		#(LimitCycles * 8);
		$display("Timeout: the tests did not finish within %0d cycles", LimitCycles);
		$display("Errors found");
		$finish;
	end

endmodule
